/* all.f */
source/lin_class_types_pkg.sv
source/lin_class_coef_pkg.sv
source/term_if.sv
source/term_gen.sv
source/split_adder.sv
source/decision_stage.sv
source/lin_class.sv
verif/lin_class_checker.sv
verif/tb_lin_class.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_lin_class
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_lin_class.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lin_class;

	// Pipeline depth in edges, also the idle cycles after each test
	localparam int DRAIN = 3;
	localparam int CLK_NS = 8;
	// Reset, corners, weights, sign, stream
	localparam int TOTAL_CYC = 3 + (7 + DRAIN) + (192 + DRAIN) + (3 + DRAIN) + (64 + DRAIN);

	logic                        i_clk;
	logic                        i_rst_n;
	lin_class_types_pkg::pixel_t i_im1;
	lin_class_types_pkg::pixel_t i_im2;
	lin_class_types_pkg::pixel_t i_im3;
	lin_class_types_pkg::wgt_t   o_wgt_sum;
	logic                        o_pos;

	// One entry per driven cycle, front entry is at the output
	int    exp_q[$];
	bit    vld_q[$];
	string name_q[$];
	// Actual sums of the running test, in input order
	int    act_log[$];

	int          n_tests = 0;
	int          n_bad_tests = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	int          test_errors = 0;
	logic [31:0] lcg_state;

	lin_class u_dut (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_im1     (i_im1),
		.i_im2     (i_im2),
		.i_im3     (i_im3),
		.o_wgt_sum (o_wgt_sum),
		.o_pos     (o_pos)
	);

	always #(CLK_NS / 2) i_clk = ~i_clk;

	// Watchdog
	initial begin
		#((TOTAL_CYC + 50) * CLK_NS);
		$display("Watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////
	// Model and helpers
	////////////////////////////////////////

	function automatic int model_sum(input int im1, input int im2, input int im3);
		return lin_class_coef_pkg::W_IM1 * im1 + im2 + lin_class_coef_pkg::BIAS
			+ lin_class_coef_pkg::W_IM3 * im3;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_sum(input string name, input lin_class_types_pkg::wgt_t exp_v,
		input lin_class_types_pkg::wgt_t act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			test_errors++;
			$display("Mismatch %s: expected %0d, actual %0d", name, exp_v, act_v);
		end
	endtask

	task automatic check_pos(input string name, input logic exp_v, input logic act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			test_errors++;
			$display("Mismatch %s: expected o_pos %0b, actual %0b", name, exp_v, act_v);
		end
	endtask

	// One clock, check the result of three edges ago, then drive
	task automatic cycle(input string name, input bit vld, input int im1, input int im2,
		input int im3);
		int    exp_v;
		bit    was_vld;
		string was_name;
		@(posedge i_clk);
		#1;
		if (exp_q.size() == DRAIN) begin
			exp_v    = exp_q.pop_front();
			was_vld  = vld_q.pop_front();
			was_name = name_q.pop_front();
			if (was_vld) begin
				check_sum(was_name, lin_class_types_pkg::wgt_t'(exp_v), o_wgt_sum);
				check_pos(was_name, logic'(exp_v >= 0), o_pos);
				act_log.push_back(int'(o_wgt_sum));
			end
		end
		i_im1 = lin_class_types_pkg::pixel_t'(im1);
		i_im2 = lin_class_types_pkg::pixel_t'(im2);
		i_im3 = lin_class_types_pkg::pixel_t'(im3);
		exp_q.push_back(model_sum(im1, im2, im3));
		vld_q.push_back(vld);
		name_q.push_back(name);
	endtask

	// Idle inputs until the last valid result is checked
	task automatic drain();
		repeat (DRAIN) cycle("idle", 1'b0, 0, 0, 0);
	endtask

	task automatic start_test();
		test_errors = 0;
		act_log.delete();
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (test_errors != 0) begin
			n_bad_tests++;
		end
		$display("Test %s finished with %0d errors", name, test_errors);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_reset();
		start_test();
		i_rst_n = 1'b0;
		repeat (2) @(posedge i_clk);
		#1;
		check_sum("reset", '0, o_wgt_sum);
		check_pos("reset", 1'b0, o_pos);
		i_rst_n = 1'b1;
		// Still cleared before the first edge out of reset
		#1;
		check_sum("reset", '0, o_wgt_sum);
		check_pos("reset", 1'b0, o_pos);
		end_test("reset");
	endtask

	task automatic test_corners();
		int c1[7] = '{0, -32, 31, -32, 31, 31, -32};
		int c2[7] = '{0, -32, 31, 31, -32, 31, -32};
		int c3[7] = '{0, -32, 31, 31, -32, -32, 31};
		start_test();
		for (int n = 0; n < 7; n++) begin
			cycle("corners", 1'b1, c1[n], c2[n], c3[n]);
		end
		drain();
		// Largest magnitudes of the sum
		check_sum("corners", -16'sd1844, lin_class_types_pkg::wgt_t'(act_log[1]));
		check_sum("corners", 16'sd1936, lin_class_types_pkg::wgt_t'(act_log[2]));
		end_test("corners");
	endtask

	task automatic test_weights();
		int slope[3] = '{lin_class_coef_pkg::W_IM1, 1, lin_class_coef_pkg::W_IM3};
		start_test();
		for (int w = 0; w < 3; w++) begin
			for (int v = -32; v <= 31; v++) begin
				cycle("weights", 1'b1, (w == 0) ? v : 0, (w == 1) ? v : 0, (w == 2) ? v : 0);
			end
		end
		drain();
		if (act_log.size() != 192) begin
			n_errors++;
			test_errors++;
			$display("Weight test captured %0d results instead of 192", act_log.size());
		end else begin
			// Step of one input gives exactly its weight
			for (int w = 0; w < 3; w++) begin
				for (int k = 1; k < 64; k++) begin
					check_sum("weights", lin_class_types_pkg::wgt_t'(slope[w]),
						lin_class_types_pkg::wgt_t'(act_log[w * 64 + k] - act_log[w * 64 + k - 1]));
				end
			end
		end
		end_test("weights");
	endtask

	task automatic test_sign();
		start_test();
		// Sums of -1, 0 and +1
		cycle("sign", 1'b1, -4, -3, -1);
		cycle("sign", 1'b1, -4, -2, -1);
		cycle("sign", 1'b1, -4, -1, -1);
		drain();
		check_sum("sign", -16'sd1, lin_class_types_pkg::wgt_t'(act_log[0]));
		check_sum("sign", 16'sd0, lin_class_types_pkg::wgt_t'(act_log[1]));
		check_sum("sign", 16'sd1, lin_class_types_pkg::wgt_t'(act_log[2]));
		end_test("sign");
	endtask

	task automatic test_stream();
		int im1;
		int im2;
		int im3;
		start_test();
		for (int n = 0; n < 64; n++) begin
			lcg_state = lcg_next(lcg_state);
			im1 = int'(lin_class_types_pkg::pixel_t'(lcg_state[29:24]));
			im2 = int'(lin_class_types_pkg::pixel_t'(lcg_state[21:16]));
			im3 = int'(lin_class_types_pkg::pixel_t'(lcg_state[13:8]));
			cycle("stream", 1'b1, im1, im2, im3);
		end
		drain();
		end_test("stream");
	endtask

	initial begin
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_im1 = '0;
		i_im2 = '0;
		i_im3 = '0;
		lcg_state = 32'h32ed_34fc;
		test_reset();
		test_corners();
		test_weights();
		test_sign();
		test_stream();
		$display("Tests %0d, with errors %0d, checks %0d, errors %0d, assertion failures %0d",
			n_tests, n_bad_tests, n_checks, n_errors, u_dut.u_chk.fail_cnt);
		if (n_errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/lin_class_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lin_class_checker (
	input logic                        i_clk,
	input logic                        i_rst_n,
	input lin_class_types_pkg::pixel_t i_im1,
	input lin_class_types_pkg::pixel_t i_im2,
	input lin_class_types_pkg::pixel_t i_im3,
	input lin_class_types_pkg::wgt_t   i_wgt_sum,
	input logic                        i_pos
);

	// Edges since reset release, saturates at the pipeline depth
	logic [1:0] warm_cnt;

	// Assertion failures seen so far
	int fail_cnt = 0;

	function automatic lin_class_types_pkg::wgt_t model_sum(
		input lin_class_types_pkg::pixel_t a,
		input lin_class_types_pkg::pixel_t b,
		input lin_class_types_pkg::pixel_t c
	);
		return lin_class_types_pkg::wgt_t'(lin_class_coef_pkg::W_IM1 * int'(a) + int'(b)
			+ lin_class_coef_pkg::BIAS + lin_class_coef_pkg::W_IM3 * int'(c));
	endfunction

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			warm_cnt <= '0;
		end else if (warm_cnt != 2'd3) begin
			warm_cnt <= warm_cnt + 2'd1;
		end
	end

	////////////////////////////////////////
	// Output properties
	////////////////////////////////////////

	// Bits 15 to 11 all copies of the sign
	ap_sign_ext: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wgt_sum[15:11] == {5{i_wgt_sum[11]}})
		else begin
			$error("Output sum is not sign extended from bit 11");
			fail_cnt++;
		end

	// Flag follows the sign once out of the reset state
	ap_pos_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_wgt_sum == '0 && !i_pos) |-> (i_pos == !i_wgt_sum[15]))
		else begin
			$error("Positive flag disagrees with the sign of the output sum");
			fail_cnt++;
		end

	// Result of the inputs three edges back
	ap_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(warm_cnt == 2'd3) |->
		(i_wgt_sum == model_sum($past(i_im1, 3), $past(i_im2, 3), $past(i_im3, 3))))
		else begin
			$error("Output sum does not match the inputs of three edges earlier");
			fail_cnt++;
		end

endmodule

bind lin_class lin_class_checker u_chk (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_im1     (i_im1),
	.i_im2     (i_im2),
	.i_im3     (i_im3),
	.i_wgt_sum (o_wgt_sum),
	.i_pos     (o_pos)
);

`default_nettype wire

/* source/lin_class.sv */
`timescale 1ns/1ps
`default_nettype none

// Pipelined linear classifier
// 5*im1 + im2 + 76 + 54*im3, three edges of latency
module lin_class #(
	parameter int LOW_W = lin_class_types_pkg::LOW_W
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  lin_class_types_pkg::pixel_t i_im1,
	input  lin_class_types_pkg::pixel_t i_im2,
	input  lin_class_types_pkg::pixel_t i_im3,
	output lin_class_types_pkg::wgt_t   o_wgt_sum,
	output logic                        o_pos
);

	// First-stage terms
	term_if u_terms ();

	// Adder operands widened to part_t
	lin_class_types_pkg::part_t add_a_op_a;
	lin_class_types_pkg::part_t add_a_op_b;
	lin_class_types_pkg::part_t add_b_op_a;
	lin_class_types_pkg::part_t add_b_op_b;

	// Second-stage partial sums
	lin_class_types_pkg::part_t part_a;
	lin_class_types_pkg::part_t part_b;

	////////////////////////////////////////
	// Stage 1, constant terms
	////////////////////////////////////////

	term_gen u_term_gen (
		.i_im1   (i_im1),
		.i_im2   (i_im2),
		.i_im3   (i_im3),
		.o_terms (u_terms.src)
	);

	// Sign extension only, no logic
	assign add_a_op_a = lin_class_types_pkg::part_t'(u_terms.t_im1);
	assign add_a_op_b = lin_class_types_pkg::part_t'(u_terms.t_im2);
	assign add_b_op_a = lin_class_types_pkg::part_t'(u_terms.t_im3a);
	assign add_b_op_b = lin_class_types_pkg::part_t'(u_terms.t_im3b);

	////////////////////////////////////////
	// Stage 2, partial sums
	////////////////////////////////////////

	// 5*im1 + (im2 + 76)
	split_adder #(
		.LOW_W (LOW_W),
		.SHIFT (0)
	) u_add_a (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_a     (add_a_op_a),
		.i_b     (add_a_op_b),
		.o_sum   (part_a)
	);

	// 8*(7*im3) + (-2*im3)
	split_adder #(
		.LOW_W (LOW_W),
		.SHIFT (lin_class_coef_pkg::SHIFT_A)
	) u_add_b (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_a     (add_b_op_a),
		.i_b     (add_b_op_b),
		.o_sum   (part_b)
	);

	////////////////////////////////////////
	// Stage 3, final sum and decision
	////////////////////////////////////////

	decision_stage #(
		.LOW_W (LOW_W)
	) u_decision (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_part_a  (part_a),
		.i_part_b  (part_b),
		.o_wgt_sum (o_wgt_sum),
		.o_pos     (o_pos)
	);

endmodule

`default_nettype wire

/* source/decision_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decision_stage #(
	parameter int LOW_W = lin_class_types_pkg::LOW_W
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  lin_class_types_pkg::part_t i_part_a,
	input  lin_class_types_pkg::part_t i_part_b,
	output lin_class_types_pkg::wgt_t  o_wgt_sum,
	output logic                       o_pos
);

	////////////////////////////////////////
	// Final addition
	////////////////////////////////////////

	// Sign bit position of the full sum
	localparam int SUM_MSB = $bits(lin_class_types_pkg::part_t) - 1;

	// Full classifier sum
	lin_class_types_pkg::part_t sum;

	// Third adder of the tree, no shift
	// Its low half registers at edge k+1
	split_adder #(
		.LOW_W (LOW_W),
		.SHIFT (0)
	) u_add_c (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_a     (i_part_a),
		.i_b     (i_part_b),
		.o_sum   (sum)
	);

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	// Loads at edge k+2
	// Sum and flag come from the same result
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wgt_sum <= '0;
			o_pos     <= 1'b0;
		end else begin
			// Cast keeps the sign, four copies of bit 11 on top
			o_wgt_sum <= lin_class_types_pkg::wgt_t'(sum);
			// Zero counts as positive
			o_pos     <= ~sum[SUM_MSB];
		end
	end

endmodule

`default_nettype wire

/* source/split_adder.sv */
`timescale 1ns/1ps
`default_nettype none

// (a << SHIFT) + b over two phases
// Low half plus carry is registered at the edge
// High half is added afterwards from registered operand bits
module split_adder #(
	parameter int LOW_W = lin_class_types_pkg::LOW_W,
	parameter int SHIFT = 0
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  lin_class_types_pkg::part_t i_a,
	input  lin_class_types_pkg::part_t i_b,
	output lin_class_types_pkg::part_t o_sum
);

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////

	// Full sum width
	localparam int SUM_W = $bits(lin_class_types_pkg::part_t);

	// Late half width
	localparam int HIGH_W = SUM_W - LOW_W;

	// Operand a after the shift
	lin_class_types_pkg::part_t a_shl;

	// Early half with its carry out on top
	logic [LOW_W:0] low_sum;

	// Registered early result
	logic [LOW_W-1:0] low_q;
	logic             carry_q;

	// Registered high operand bits
	logic [HIGH_W-1:0] a_high_q;
	logic [HIGH_W-1:0] b_high_q;

	// Late half
	logic [HIGH_W-1:0] high_sum;

	////////////////////////////////////////
	// Early phase
	////////////////////////////////////////

	// Arithmetic shift, bits falling off the top are never set
	// for the ranges this adder sees
	assign a_shl = i_a <<< SHIFT;

	// Zero-extend both halves by one bit to catch the carry
	assign low_sum = {1'b0, a_shl[LOW_W-1:0]} + {1'b0, i_b[LOW_W-1:0]};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			low_q    <= '0;
			carry_q  <= 1'b0;
			a_high_q <= '0;
			b_high_q <= '0;
		end else begin
			// Finished low bits
			low_q    <= low_sum[LOW_W-1:0];
			// Carry into the high half
			carry_q  <= low_sum[LOW_W];
			// Untouched high operands
			a_high_q <= a_shl[SUM_W-1:LOW_W];
			b_high_q <= i_b[SUM_W-1:LOW_W];
		end
	end

	////////////////////////////////////////
	// Late phase
	////////////////////////////////////////

	// Two's complement wraps the same for signed and unsigned
	// so the top bits need no sign handling here
	assign high_sum = a_high_q + b_high_q + HIGH_W'(carry_q);

	// Whole result is valid one edge after the operands
	assign o_sum = {high_sum, low_q};

endmodule

`default_nettype wire

/* source/term_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module term_gen (
	input  lin_class_types_pkg::pixel_t i_im1,
	input  lin_class_types_pkg::pixel_t i_im2,
	input  lin_class_types_pkg::pixel_t i_im3,
	term_if.src                         o_terms
);

	////////////////////////////////////////
	// Shift amounts
	////////////////////////////////////////

	// 5 = 4 + 1
	localparam int SH_IM1 = $clog2(lin_class_coef_pkg::W_IM1 - 1);

	// 7 = 8 - 1
	localparam int SH_IM3A = $clog2(lin_class_coef_pkg::W_IM3_A + 1);

	// -2 = -(2)
	localparam int SH_IM3B = $clog2(-lin_class_coef_pkg::W_IM3_B);

	// Inputs widened to the term width
	lin_class_types_pkg::term_t im1_x;
	lin_class_types_pkg::term_t im2_x;
	lin_class_types_pkg::term_t im3_x;

	// Bias as a term-width constant
	lin_class_types_pkg::term_t bias_x;

	// Shifted copies
	lin_class_types_pkg::term_t im1_sh;
	lin_class_types_pkg::term_t im3_sh_a;
	lin_class_types_pkg::term_t im3_sh_b;

	////////////////////////////////////////
	// Sign extension
	////////////////////////////////////////

	// All three samples are signed, cast keeps the sign
	assign im1_x = lin_class_types_pkg::term_t'(i_im1);
	assign im2_x = lin_class_types_pkg::term_t'(i_im2);
	assign im3_x = lin_class_types_pkg::term_t'(i_im3);

	// 76 fits easily in 9 bits
	assign bias_x = lin_class_types_pkg::term_t'(lin_class_coef_pkg::BIAS);

	////////////////////////////////////////
	// Constant products
	////////////////////////////////////////

	// 5*im1 as im1 + 4*im1
	// Range -160 to 155
	assign im1_sh = im1_x <<< SH_IM1;
	assign o_terms.t_im1 = im1_x + im1_sh;

	// im2 + 76
	// Always positive, 44 to 107
	assign o_terms.t_im2 = im2_x + bias_x;

	// 7*im3 as 8*im3 - im3
	// 8*(-32) = -256 is still representable
	assign im3_sh_a = im3_x <<< SH_IM3A;
	assign o_terms.t_im3a = im3_sh_a - im3_x;

	// -2*im3 as a negated single shift
	// Range -62 to 64
	assign im3_sh_b = im3_x <<< SH_IM3B;
	assign o_terms.t_im3b = -im3_sh_b;

	// No clock here
	// The terms settle from the inputs in the same cycle
	// and are sampled by the split adders at the next edge

endmodule

`default_nettype wire

/* source/term_if.sv */
`timescale 1ns/1ps
`default_nettype none

// First-stage terms from term_gen to the adder tree
// No handshake, the terms are plain combinational levels
interface term_if;

	// 5*im1
	lin_class_types_pkg::term_t t_im1;

	// im2 + bias
	lin_class_types_pkg::term_t t_im2;

	// 7*im3, shifted later in the second stage
	lin_class_types_pkg::term_t t_im3a;

	// -2*im3
	lin_class_types_pkg::term_t t_im3b;

	// Producer side
	modport src (
		output t_im1,
		output t_im2,
		output t_im3a,
		output t_im3b
	);

	// Consumer side
	modport snk (
		input t_im1,
		input t_im2,
		input t_im3a,
		input t_im3b
	);

endinterface

`default_nettype wire

/* source/lin_class_coef_pkg.sv */
`default_nettype none

package lin_class_coef_pkg;

	////////////////////////////////////////
	// Classifier weights
	////////////////////////////////////////

	// Weight of im1, built as im1 + 4*im1
	localparam int W_IM1 = 5;

	// Offset folded into the im2 term
	localparam int BIAS = 76;

	// im3 weight is split in two terms
	// 54 = 8*(7*im3) + (-2*im3)
	localparam int W_IM3_A = 7;
	localparam int W_IM3_B = -2;

	// Left shift of the 7*im3 term in the second stage
	localparam int SHIFT_A = 3;

	// Effective im3 weight after recombination
	localparam int W_IM3 = 54;

	// im2 itself has unit weight
	// so it needs no constant of its own

endpackage

`default_nettype wire

/* source/lin_class_types_pkg.sv */
`default_nettype none

package lin_class_types_pkg;

	////////////////////////////////////////
	// Datapath vector types
	////////////////////////////////////////

	// One raw input sample, two's complement
	typedef logic signed [5:0] pixel_t;

	// First-stage weighted term
	// Widest case is 8*im3 before the subtract, -256
	typedef logic signed [8:0] term_t;

	// Partial sums and the full classifier sum
	// Range of the full sum is -1844 to 1936
	typedef logic signed [11:0] part_t;

	// Output word, sign extended from part_t
	typedef logic signed [15:0] wgt_t;

	////////////////////////////////////////
	// Split adder geometry
	////////////////////////////////////////

	// Bits added and registered in the early half
	localparam int LOW_W = 6;

endpackage

`default_nettype wire
